//--- addrgen.f
+incdir+hdl
hdl/addrgen_pkg.sv
hdl/addrgen_if.sv
hdl/insn_decoder.sv
hdl/burst_sequencer.sv
hdl/stride_sequencer.sv
hdl/ax_issuer.sv
hdl/addrgen.sv
verif/addrgen_properties.sv
verif/addrgen_tb.sv

//--- Bender.yml
package:
  name: addrgen

export_include_dirs:
  - hdl

sources:
  - target: rtl
    include_dirs:
      - hdl
    files:
      - hdl/addrgen_pkg.sv
      - hdl/addrgen_if.sv
      - hdl/insn_decoder.sv
      - hdl/burst_sequencer.sv
      - hdl/stride_sequencer.sv
      - hdl/ax_issuer.sv
      - hdl/addrgen.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/addrgen_properties.sv
      - verif/addrgen_tb.sv

//--- verif/addrgen_patterns.txt
# name addr len stride vew is_load is_unit stall err count first_len last_addr
# all values in hex, expected results are the last four columns
unit_ld_page     00001000 0010 00000000 3 1 1 0 0 0001 0f 00001000
unit_ld_unal     00002004 000a 00000000 2 1 1 0 0 0001 05 00002004
unit_st_cross    00000fc0 0020 00000000 3 0 1 0 0 0002 07 00001000
unit_ld_long     00000000 0300 00000000 3 1 1 0 0 0003 ff 00001000
unit_ld_long_pg  00003c00 0200 00000000 3 1 1 0 0 0003 7f 00004800
stride_st        00000100 0005 00000040 2 0 0 0 0 0005 00 00000200
stride_ld_neg    00008000 0004 fffffff8 3 1 0 0 0 0004 00 00007fe8
misalign_unit    00001002 0008 00000000 2 1 1 0 1 0000 00 00000000
misalign_stride  00000203 0004 00000010 1 0 0 0 1 0000 00 00000000
stall_ld_unit    00005000 0180 00000000 3 1 1 1 0 0002 ff 00005800
stall_ld_stride  00007000 0006 00000004 2 1 0 1 0 0006 00 00007014
stall_st_stride  00006000 0008 00000010 3 0 0 1 0 0008 00 00006070
stall_st_unit    00009008 0020 00000000 3 0 1 1 0 0001 1f 00009008
stall_ld_cross   0000aff0 0010 00000000 2 1 1 1 0 0002 01 0000b000

//--- verif/addrgen_tb.sv
////////////////////////////////////////////////////////////
// Address generator testbench
// Pattern-driven tests with random stalls and a descriptor scoreboard
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "addrgen_cfg.svh"

module addrgen_tb;
  import addrgen_pkg::*;

  localparam addr_t BEAT_BYTES = addr_t'(`ADDRGEN_DATA_BYTES);
  localparam size_t BEAT_SIZE  = size_t'(`ADDRGEN_DATA_SIZE);
  localparam int    QDEPTH     = `ADDRGEN_QUEUE_DEPTH;

  logic      clk_i;
  logic      rst_ni;
  logic      req_valid_i;
  addr_t     req_addr_i;
  vlen_t     req_len_i;
  stride_t   req_stride_i;
  size_t     req_vew_i;
  logic      req_is_load_i;
  logic      req_is_unit_i;
  logic      ack_o;
  logic      error_o;
  logic      ar_valid_o;
  addr_t     ar_addr_o;
  beat_len_t ar_len_o;
  size_t     ar_size_o;
  logic      ar_ready_i;
  logic      aw_valid_o;
  addr_t     aw_addr_o;
  beat_len_t aw_len_o;
  size_t     aw_size_o;
  logic      aw_ready_i;
  logic      desc_valid_o;
  addr_t     desc_addr_o;
  beat_len_t desc_len_o;
  size_t     desc_size_o;
  logic      desc_is_load_o;
  logic      desc_ready_i;

  // Pattern table, one entry per test
  string     t_name[$];
  addr_t     t_addr[$];
  vlen_t     t_len[$];
  stride_t   t_stride[$];
  size_t     t_vew[$];
  logic      t_load[$];
  logic      t_unit[$];
  logic      t_stall[$];
  logic      t_err[$];
  vlen_t     t_count[$];
  beat_len_t t_first[$];
  addr_t     t_last[$];

  // Running test as seen by the monitor
  string     cur_name;
  stride_t   cur_stride;
  size_t     cur_vew;
  logic      cur_load;
  logic      cur_unit;
  vlen_t     req_cnt;
  beat_len_t first_len;
  addr_t     last_addr;
  // Where the next request must start
  addr_t     exp_next;

  // Issued requests still waiting in the DUT queue
  addr_t     pend_addr[$];
  beat_len_t pend_len[$];
  size_t     pend_size[$];
  logic      pend_load[$];

  logic        stall_en;
  logic [31:0] lcg_state;
  logic        running;
  int          err_count;
  int          n_checks;
  int          fail_tests;
  int          cycle_cnt;
  int          cycle_limit;

  addrgen uut (.*);

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_addr(input string label, input addr_t exp, input addr_t act);
    n_checks++;
    if (exp !== act) begin
      err_count++;
      $display("** Error [%s] %s: expected %h, actual %h", cur_name, label, exp, act);
    end
  endtask

  task automatic check_len(input string label, input beat_len_t exp, input beat_len_t act);
    n_checks++;
    if (exp !== act) begin
      err_count++;
      $display("** Error [%s] %s: expected %h, actual %h", cur_name, label, exp, act);
    end
  endtask

  task automatic check_size(input string label, input size_t exp, input size_t act);
    n_checks++;
    if (exp !== act) begin
      err_count++;
      $display("** Error [%s] %s: expected %h, actual %h", cur_name, label, exp, act);
    end
  endtask

  task automatic check_flag(input string label, input logic exp, input logic act);
    n_checks++;
    if (exp !== act) begin
      err_count++;
      $display("** Error [%s] %s: expected %b, actual %b", cur_name, label, exp, act);
    end
  endtask

  task automatic check_count(input string label, input vlen_t exp, input vlen_t act);
    n_checks++;
    if (exp !== act) begin
      err_count++;
      $display("** Error [%s] %s: expected %0d, actual %0d", cur_name, label, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////////////////////////

  // Request against the rules, queue state is the one before this edge
  task automatic inspect_request();
    logic      is_ld;
    addr_t     a;
    beat_len_t l;
    size_t     s;
    is_ld = ar_valid_o;
    a     = is_ld ? ar_addr_o : aw_addr_o;
    l     = is_ld ? ar_len_o : aw_len_o;
    s     = is_ld ? ar_size_o : aw_size_o;
    check_flag("channel", cur_load, is_ld);
    check_size("size", cur_unit ? BEAT_SIZE : cur_vew, s);
    check_addr("address", exp_next, a);
    if (!cur_unit) begin
      check_len("length", '0, l);
    end
    if (pend_addr.size() >= QDEPTH) begin
      err_count++;
      $display("[%s] request issued while the descriptor queue was full", cur_name);
    end
    // Other channel must wait for the queue to drain
    if (pend_load.size() > 0) begin
      check_flag("channel order", pend_load[0], is_ld);
    end
    if (req_cnt == 0) begin
      first_len = l;
    end
    last_addr = a;
    // Bursts are contiguous on beat boundaries
    if (cur_unit) begin
      exp_next = (a & ~(BEAT_BYTES - 1)) + ((addr_t'(l) + 1) << BEAT_SIZE);
    end else begin
      exp_next = a + cur_stride;
    end
    req_cnt++;
  endtask

  task automatic push_request();
    pend_load.push_back(ar_valid_o);
    pend_addr.push_back(ar_valid_o ? ar_addr_o : aw_addr_o);
    pend_len.push_back(ar_valid_o ? ar_len_o : aw_len_o);
    pend_size.push_back(ar_valid_o ? ar_size_o : aw_size_o);
  endtask

  task automatic pop_descriptor();
    if (pend_addr.size() == 0) begin
      err_count++;
      $display("[%s] descriptor left the queue with no request behind it", cur_name);
    end else begin
      check_addr("descriptor address", pend_addr.pop_front(), desc_addr_o);
      check_len("descriptor length", pend_len.pop_front(), desc_len_o);
      check_size("descriptor size", pend_size.pop_front(), desc_size_o);
      check_flag("descriptor is_load", pend_load.pop_front(), desc_is_load_o);
    end
  endtask

  // Sample at the falling edge, where the handshakes are settled
  always @(negedge clk_i) begin
    if (rst_ni && running) begin
      if (ar_valid_o || aw_valid_o) begin
        inspect_request();
      end
      if (desc_valid_o && desc_ready_i) begin
        pop_descriptor();
      end
      if (ar_valid_o || aw_valid_o) begin
        push_request();
      end
    end
  end

  // Channel and queue back-pressure
  always @(posedge clk_i) begin
    if (stall_en) begin
      lcg_state = lcg_next(lcg_state);
      ar_ready_i   <= |lcg_state[31:30];
      aw_ready_i   <= |lcg_state[29:28];
      // Mostly low, so descriptors pile up across instructions
      desc_ready_i <= &lcg_state[27:26];
    end else begin
      ar_ready_i   <= 1'b1;
      aw_ready_i   <= 1'b1;
      desc_ready_i <= 1'b1;
    end
  end

  always @(posedge clk_i) begin
    if (running) begin
      cycle_cnt++;
      if (cycle_cnt > cycle_limit) begin
        $display("Timeout: the DUT did not finish within %0d cycles", cycle_limit);
        $display("Done: errors found");
        $finish;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  task automatic load_patterns();
    int        fd;
    int        n;
    string     line;
    string     name;
    addr_t     a;
    vlen_t     l;
    stride_t   st;
    size_t     v;
    logic      ld;
    logic      un;
    logic      sl;
    logic      er;
    vlen_t     cnt;
    beat_len_t fl;
    addr_t     la;
    fd = $fopen("verif/addrgen_patterns.txt", "r");
    if (fd == 0) begin
      err_count++;
      $display("Cannot open the pattern file");
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // Skip comments and blank lines
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h",
                    name, a, l, st, v, ld, un, sl, er, cnt, fl, la);
        if (n == 12) begin
          t_name.push_back(name);
          t_addr.push_back(a);
          t_len.push_back(l);
          t_stride.push_back(st);
          t_vew.push_back(v);
          t_load.push_back(ld);
          t_unit.push_back(un);
          t_stall.push_back(sl);
          t_err.push_back(er);
          t_count.push_back(cnt);
          t_first.push_back(fl);
          t_last.push_back(la);
        end else begin
          err_count++;
          $display("Malformed pattern line: %s", line);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_test(input int t);
    int errs_before;
    errs_before = err_count;
    @(posedge clk_i);
    cur_name   = t_name[t];
    cur_stride = t_stride[t];
    cur_vew    = t_vew[t];
    cur_load   = t_load[t];
    cur_unit   = t_unit[t];
    req_cnt    = '0;
    first_len  = '0;
    last_addr  = '0;
    exp_next   = t_addr[t];
    stall_en      <= t_stall[t];
    req_valid_i   <= 1'b1;
    req_addr_i    <= t_addr[t];
    req_len_i     <= t_len[t];
    req_stride_i  <= t_stride[t];
    req_vew_i     <= t_vew[t];
    req_is_load_i <= t_load[t];
    req_is_unit_i <= t_unit[t];
    // Instruction ends with the ack pulse
    do begin
      @(negedge clk_i);
    end while (!ack_o);
    check_flag("error", t_err[t], error_o);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    check_count("request count", t_count[t], req_cnt);
    if (t_count[t] != 0) begin
      check_len("first length", t_first[t], first_len);
      check_addr("last address", t_last[t], last_addr);
    end
    // Bursts must reach the last byte of the vector
    if (t_unit[t] && !t_err[t]) begin
      check_flag("length covered", 1'b1,
                 exp_next >= t_addr[t] + (addr_t'(t_len[t]) << t_vew[t]));
    end
    if (err_count != errs_before) begin
      fail_tests++;
    end
    $display("%-16s %s, %0d requests", cur_name,
             (err_count == errs_before) ? "ok" : "FAILED", req_cnt);
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    req_valid_i   = 1'b0;
    req_addr_i    = '0;
    req_len_i     = '0;
    req_stride_i  = '0;
    req_vew_i     = '0;
    req_is_load_i = 1'b0;
    req_is_unit_i = 1'b0;
    ar_ready_i    = 1'b1;
    aw_ready_i    = 1'b1;
    desc_ready_i  = 1'b1;
    stall_en      = 1'b0;
    lcg_state     = 32'h98e3_0748;
    running       = 1'b0;
    err_count     = 0;
    n_checks      = 0;
    fail_tests    = 0;
    cycle_cnt     = 0;
    cur_name      = "reset";
    load_patterns();
    if (t_name.size() == 0) begin
      err_count++;
      $display("No tests were loaded");
    end
    // Slack per test plus room for each request
    cycle_limit = 0;
    foreach (t_count[i]) begin
      cycle_limit += 20 + 8 * int'(t_count[i]);
    end
    repeat (7) @(posedge clk_i);
    @(negedge clk_i);
    check_flag("ack in reset", 1'b0, ack_o);
    check_flag("error in reset", 1'b0, error_o);
    check_flag("AR valid in reset", 1'b0, ar_valid_o);
    check_flag("AW valid in reset", 1'b0, aw_valid_o);
    check_flag("descriptor valid in reset", 1'b0, desc_valid_o);
    @(posedge clk_i);
    rst_ni  <= 1'b1;
    running = 1'b1;
    foreach (t_name[i]) begin
      run_test(i);
    end
    // Let the last descriptors leave the queue
    do begin
      @(negedge clk_i);
    end while (desc_valid_o || pend_addr.size() != 0);
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             t_name.size(), fail_tests, n_checks, err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/addrgen_properties.sv
////////////////////////////////////////////////////////////
// Address generator port assertions, bound to the top level
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module addrgen_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic ack_o,
  input logic error_o,
  input logic ar_valid_o,
  input logic ar_ready_i,
  input logic aw_valid_o,
  input logic aw_ready_i
);

  // Only one channel issues per cycle
  one_channel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(ar_valid_o && aw_valid_o))
    else $error("AR and AW valid in the same cycle");

  // Valid is only raised against a ready channel
  ar_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o |-> ar_ready_i)
    else $error("AR valid without AR ready");
  aw_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o |-> aw_ready_i)
    else $error("AW valid without AW ready");

  // Acknowledge is a single pulse
  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o |=> !ack_o)
    else $error("ack held for more than one cycle");

  error_with_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    error_o |-> ack_o)
    else $error("error raised without ack");

endmodule

bind addrgen addrgen_properties i_properties (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .ack_o      (ack_o),
  .error_o    (error_o),
  .ar_valid_o (ar_valid_o),
  .ar_ready_i (ar_ready_i),
  .aw_valid_o (aw_valid_o),
  .aw_ready_i (aw_ready_i)
);

`default_nettype wire

//--- hdl/addrgen.sv
////////////////////////////////////////////////////////////
// Vector load/store address generator top level
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module addrgen (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Instruction
  input  logic                   req_valid_i,
  input  addrgen_pkg::addr_t     req_addr_i,
  input  addrgen_pkg::vlen_t     req_len_i,
  input  addrgen_pkg::stride_t   req_stride_i,
  input  addrgen_pkg::size_t     req_vew_i,
  input  logic                   req_is_load_i,
  input  logic                   req_is_unit_i,
  output logic                   ack_o,
  output logic                   error_o,
  // AR channel
  output logic                   ar_valid_o,
  output addrgen_pkg::addr_t     ar_addr_o,
  output addrgen_pkg::beat_len_t ar_len_o,
  output addrgen_pkg::size_t     ar_size_o,
  input  logic                   ar_ready_i,
  // AW channel
  output logic                   aw_valid_o,
  output addrgen_pkg::addr_t     aw_addr_o,
  output addrgen_pkg::beat_len_t aw_len_o,
  output addrgen_pkg::size_t     aw_size_o,
  input  logic                   aw_ready_i,
  // Descriptors to the load/store units
  output logic                   desc_valid_o,
  output addrgen_pkg::addr_t     desc_addr_o,
  output addrgen_pkg::beat_len_t desc_len_o,
  output addrgen_pkg::size_t     desc_size_o,
  output logic                   desc_is_load_o,
  input  logic                   desc_ready_i
);

  // Decoder to sequencer commands
  seq_if burst_cmd ();
  seq_if stride_cmd ();
  // Sequencer to issuer requests
  ax_if  burst_req ();
  ax_if  stride_req ();

  insn_decoder i_decoder (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_addr_i    (req_addr_i),
    .req_len_i     (req_len_i),
    .req_stride_i  (req_stride_i),
    .req_vew_i     (req_vew_i),
    .req_is_load_i (req_is_load_i),
    .req_is_unit_i (req_is_unit_i),
    .burst_o       (burst_cmd),
    .stride_o      (stride_cmd),
    .ack_o         (ack_o),
    .error_o       (error_o)
  );

  burst_sequencer i_burst_seq (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .cmd_i  (burst_cmd),
    .ax_o   (burst_req)
  );

  stride_sequencer i_stride_seq (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .cmd_i  (stride_cmd),
    .ax_o   (stride_req)
  );

  ax_issuer i_issuer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .burst_i        (burst_req),
    .stride_i       (stride_req),
    .ar_valid_o     (ar_valid_o),
    .ar_addr_o      (ar_addr_o),
    .ar_len_o       (ar_len_o),
    .ar_size_o      (ar_size_o),
    .ar_ready_i     (ar_ready_i),
    .aw_valid_o     (aw_valid_o),
    .aw_addr_o      (aw_addr_o),
    .aw_len_o       (aw_len_o),
    .aw_size_o      (aw_size_o),
    .aw_ready_i     (aw_ready_i),
    .desc_valid_o   (desc_valid_o),
    .desc_addr_o    (desc_addr_o),
    .desc_len_o     (desc_len_o),
    .desc_size_o    (desc_size_o),
    .desc_is_load_o (desc_is_load_o),
    .desc_ready_i   (desc_ready_i)
  );

endmodule

`default_nettype wire

//--- hdl/ax_issuer.sv
////////////////////////////////////////////////////////////
// Request issuer
// Orders AR/AW requests and queues descriptors for the LSUs
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "addrgen_cfg.svh"

module ax_issuer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  ax_if.issuer                   burst_i,
  ax_if.issuer                   stride_i,
  output logic                   ar_valid_o,
  output addrgen_pkg::addr_t     ar_addr_o,
  output addrgen_pkg::beat_len_t ar_len_o,
  output addrgen_pkg::size_t     ar_size_o,
  input  logic                   ar_ready_i,
  output logic                   aw_valid_o,
  output addrgen_pkg::addr_t     aw_addr_o,
  output addrgen_pkg::beat_len_t aw_len_o,
  output addrgen_pkg::size_t     aw_size_o,
  input  logic                   aw_ready_i,
  output logic                   desc_valid_o,
  output addrgen_pkg::addr_t     desc_addr_o,
  output addrgen_pkg::beat_len_t desc_len_o,
  output addrgen_pkg::size_t     desc_size_o,
  output logic                   desc_is_load_o,
  input  logic                   desc_ready_i
);
  import addrgen_pkg::*;

  localparam int unsigned DEPTH = `ADDRGEN_QUEUE_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // Selected request, at most one sequencer is active
  logic      req_valid;
  addr_t     req_addr;
  beat_len_t req_len;
  size_t     req_size;
  logic      req_is_load;

  logic order_ok;
  logic chan_ready;
  logic q_full;
  logic q_empty;
  logic grant;
  logic pop;

  // Descriptor queue storage
  addr_t            q_addr [DEPTH];
  beat_len_t        q_len  [DEPTH];
  size_t            q_size [DEPTH];
  logic             q_load [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  ////////////////////////////////////////////////////////////
  // Arbitration and channel drive
  ////////////////////////////////////////////////////////////

  assign req_valid   = burst_i.valid || stride_i.valid;
  assign req_addr    = burst_i.valid ? burst_i.addr : stride_i.addr;
  assign req_len     = burst_i.valid ? burst_i.len : stride_i.len;
  assign req_size    = burst_i.valid ? burst_i.size : stride_i.size;
  assign req_is_load = burst_i.valid ? burst_i.is_load : stride_i.is_load;

  assign q_empty = (count_q == '0);
  assign q_full  = (count_q == CNT_W'(DEPTH));

  // Switching channels waits for the queue to drain
  assign order_ok   = q_empty || (q_load[rd_ptr_q] == req_is_load);
  assign chan_ready = req_is_load ? ar_ready_i : aw_ready_i;
  assign grant      = req_valid && !q_full && order_ok && chan_ready;

  assign burst_i.grant  = grant && burst_i.valid;
  assign stride_i.grant = grant && !burst_i.valid;

  // Valid only in the issuing cycle
  assign ar_valid_o = grant && req_is_load;
  assign ar_addr_o  = req_addr;
  assign ar_len_o   = req_len;
  assign ar_size_o  = req_size;
  assign aw_valid_o = grant && !req_is_load;
  assign aw_addr_o  = req_addr;
  assign aw_len_o   = req_len;
  assign aw_size_o  = req_size;

  ////////////////////////////////////////////////////////////
  // Descriptor queue
  ////////////////////////////////////////////////////////////

  assign desc_valid_o   = !q_empty;
  assign desc_addr_o    = q_addr[rd_ptr_q];
  assign desc_len_o     = q_len[rd_ptr_q];
  assign desc_size_o    = q_size[rd_ptr_q];
  assign desc_is_load_o = q_load[rd_ptr_q];

  assign pop = desc_valid_o && desc_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (grant) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Push and pop together keep the count
      if (grant && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !grant) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Every grant writes one descriptor
  always_ff @(posedge clk_i) begin
    if (grant) begin
      q_addr[wr_ptr_q] <= req_addr;
      q_len[wr_ptr_q]  <= req_len;
      q_size[wr_ptr_q] <= req_size;
      q_load[wr_ptr_q] <= req_is_load;
    end
  end

endmodule

`default_nettype wire

//--- hdl/stride_sequencer.sv
////////////////////////////////////////////////////////////
// Stride sequencer
// One single-beat request per element
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module stride_sequencer (
  input  logic      clk_i,
  input  logic      rst_ni,
  seq_if.sequencer  cmd_i,
  ax_if.sequencer   ax_o
);
  import addrgen_pkg::*;

  seq_state_e state_q;

  addr_t   addr_q;
  vlen_t   rem_q;
  stride_t stride_q;
  size_t   vew_q;
  logic    is_load_q;
  logic    grant_last;

  // Element-sized single beats
  assign ax_o.valid   = (state_q == SEQ_ISSUE);
  assign ax_o.addr    = addr_q;
  assign ax_o.len     = '0;
  assign ax_o.size    = vew_q;
  assign ax_o.is_load = is_load_q;

  // Last element leaves with this grant
  assign grant_last = ax_o.grant && (rem_q == vlen_t'(1));
  assign cmd_i.done = grant_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SEQ_IDLE;
    end else begin
      case (state_q)
        SEQ_IDLE:  if (cmd_i.start) state_q <= SEQ_ISSUE;
        SEQ_ISSUE: if (grant_last) state_q <= SEQ_IDLE;
        default:   state_q <= SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_i.start) begin
      addr_q    <= cmd_i.addr;
      rem_q     <= cmd_i.len;
      stride_q  <= cmd_i.stride;
      vew_q     <= cmd_i.vew;
      is_load_q <= cmd_i.is_load;
    end else if (ax_o.grant) begin
      // Step to the next element
      addr_q <= addr_q + stride_q;
      rem_q  <= rem_q - vlen_t'(1);
    end
  end

endmodule

`default_nettype wire

//--- hdl/burst_sequencer.sv
////////////////////////////////////////////////////////////
// Burst sequencer for unit-stride accesses
// Cuts INCR bursts at 256 beats and at 4 KiB pages
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "addrgen_cfg.svh"

module burst_sequencer (
  input  logic      clk_i,
  input  logic      rst_ni,
  seq_if.sequencer  cmd_i,
  ax_if.sequencer   ax_o
);
  import addrgen_pkg::*;

  // Largest burst in bytes
  localparam addr_t MAX_BYTES = addr_t'(`ADDRGEN_MAX_BEATS * `ADDRGEN_DATA_BYTES);
  localparam addr_t BEAT_MASK = addr_t'(`ADDRGEN_DATA_BYTES - 1);
  localparam addr_t PAGE_MASK = addr_t'((1 << `ADDRGEN_PAGE_BITS) - 1);

  seq_state_e state_q;

  // Current instruction
  addr_t addr_q;
  vlen_t rem_q;
  size_t vew_q;
  logic  is_load_q;

  // Burst geometry for the current address
  addr_t start_al;
  addr_t rem_bytes;
  addr_t end_raw;
  addr_t end_lim;
  addr_t end_addr;
  addr_t consumed;
  vlen_t rem_next;
  logic  grant_last;

  ////////////////////////////////////////////////////////////
  // Burst bounds
  ////////////////////////////////////////////////////////////

  always_comb begin
    start_al  = addr_q & ~BEAT_MASK;
    rem_bytes = addr_t'(rem_q) << vew_q;
    if (rem_bytes > MAX_BYTES) begin
      rem_bytes = MAX_BYTES;
    end
    // Last byte of the final beat
    end_raw  = ((addr_q + rem_bytes - addr_t'(1)) & ~BEAT_MASK) + BEAT_MASK;
    // Unaligned start may not stretch past 256 beats
    end_lim  = start_al + MAX_BYTES - addr_t'(1);
    end_addr = (end_raw > end_lim) ? end_lim : end_raw;
    // Stay inside the start's page
    if ((end_addr & ~PAGE_MASK) != (start_al & ~PAGE_MASK)) begin
      end_addr = start_al | PAGE_MASK;
    end
    // Elements covered by this burst, saturating
    consumed = (end_addr - addr_q + addr_t'(1)) >> vew_q;
    rem_next = (addr_t'(rem_q) > consumed) ? rem_q - vlen_t'(consumed) : '0;
  end

  assign ax_o.valid   = (state_q == SEQ_ISSUE);
  assign ax_o.addr    = addr_q;
  assign ax_o.len     = beat_len_t'((end_addr - start_al) >> `ADDRGEN_DATA_SIZE);
  assign ax_o.size    = size_t'(`ADDRGEN_DATA_SIZE);
  assign ax_o.is_load = is_load_q;

  assign grant_last = ax_o.grant && (rem_next == '0);
  assign cmd_i.done = grant_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SEQ_IDLE;
    end else begin
      case (state_q)
        SEQ_IDLE:  if (cmd_i.start) state_q <= SEQ_ISSUE;
        SEQ_ISSUE: if (grant_last) state_q <= SEQ_IDLE;
        default:   state_q <= SEQ_IDLE;
      endcase
    end
  end

  // Next burst starts right after this one ends
  always_ff @(posedge clk_i) begin
    if (cmd_i.start) begin
      addr_q    <= cmd_i.addr;
      rem_q     <= cmd_i.len;
      vew_q     <= cmd_i.vew;
      is_load_q <= cmd_i.is_load;
    end else if (ax_o.grant) begin
      addr_q <= end_addr + addr_t'(1);
      rem_q  <= rem_next;
    end
  end

endmodule

`default_nettype wire

//--- hdl/insn_decoder.sv
////////////////////////////////////////////////////////////
// Instruction decoder
// Checks base alignment and dispatches to a sequencer
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_valid_i,
  input  addrgen_pkg::addr_t   req_addr_i,
  input  addrgen_pkg::vlen_t   req_len_i,
  input  addrgen_pkg::stride_t req_stride_i,
  input  addrgen_pkg::size_t   req_vew_i,
  input  logic                 req_is_load_i,
  input  logic                 req_is_unit_i,
  seq_if.decoder               burst_o,
  seq_if.decoder               stride_o,
  output logic                 ack_o,
  output logic                 error_o
);
  import addrgen_pkg::*;

  dec_state_e state_q, state_d;
  addr_t      vew_mask;
  logic       misaligned;
  // Sequencer finished, acknowledge in the next cycle
  logic       done_q;

  // Low vew bits of the base must be zero
  assign vew_mask   = (addr_t'(1) << req_vew_i) - addr_t'(1);
  assign misaligned = |(req_addr_i & vew_mask);

  // Inputs stay stable until ack, so both sequencers see them directly
  assign burst_o.addr     = req_addr_i;
  assign burst_o.len      = req_len_i;
  assign burst_o.stride   = req_stride_i;
  assign burst_o.vew      = req_vew_i;
  assign burst_o.is_load  = req_is_load_i;
  assign stride_o.addr    = req_addr_i;
  assign stride_o.len     = req_len_i;
  assign stride_o.stride  = req_stride_i;
  assign stride_o.vew     = req_vew_i;
  assign stride_o.is_load = req_is_load_i;

  always_comb begin
    state_d        = state_q;
    burst_o.start  = 1'b0;
    stride_o.start = 1'b0;
    ack_o          = 1'b0;
    error_o        = 1'b0;
    case (state_q)
      DEC_IDLE: begin
        if (req_valid_i) begin
          state_d = DEC_CHECK;
        end
      end
      DEC_CHECK: begin
        if (misaligned) begin
          // Reject without any request
          ack_o   = 1'b1;
          error_o = 1'b1;
          state_d = DEC_IDLE;
        end else begin
          // Unit-stride goes to the burst path
          burst_o.start  = req_is_unit_i;
          stride_o.start = !req_is_unit_i;
          state_d        = DEC_BUSY;
        end
      end
      DEC_BUSY: begin
        if (done_q) begin
          ack_o   = 1'b1;
          state_d = DEC_IDLE;
        end
      end
      default: state_d = DEC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DEC_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // Only the started sequencer can pulse done
      done_q  <= (state_q == DEC_BUSY) && !done_q && (burst_o.done || stride_o.done);
    end
  end

endmodule

`default_nettype wire

//--- hdl/addrgen_if.sv
////////////////////////////////////////////////////////////
// Internal links of the address generator
// Decoder to sequencer commands and sequencer to issuer requests
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

// Instruction handed from the decoder to one sequencer
interface seq_if;
  import addrgen_pkg::*;

  // One-cycle load pulse
  logic    start;
  addr_t   addr;
  vlen_t   len;
  stride_t stride;
  size_t   vew;
  logic    is_load;
  // Pulses with the grant of the final request
  logic    done;

  modport decoder (output start, addr, len, stride, vew, is_load, input done);
  modport sequencer (input start, addr, len, stride, vew, is_load, output done);
endinterface

// Address request from a sequencer to the issuer
interface ax_if;
  import addrgen_pkg::*;

  // Fields hold while valid is high
  logic      valid;
  addr_t     addr;
  beat_len_t len;
  size_t     size;
  logic      is_load;
  // Request issued in this cycle
  logic      grant;

  modport sequencer (output valid, addr, len, size, is_load, input grant);
  modport issuer (input valid, addr, len, size, is_load, output grant);
endinterface

`default_nettype wire

//--- hdl/addrgen_pkg.sv
////////////////////////////////////////////////////////////
// Address generator types
////////////////////////////////////////////////////////////

`default_nettype none

`include "addrgen_cfg.svh"

package addrgen_pkg;

  // Byte address and byte stride
  typedef logic [`ADDRGEN_ADDR_W-1:0] addr_t;
  typedef logic [`ADDRGEN_ADDR_W-1:0] stride_t;

  // Remaining elements of an instruction
  typedef logic [`ADDRGEN_LEN_W-1:0] vlen_t;

  // Burst length in beats minus one
  typedef logic [$clog2(`ADDRGEN_MAX_BEATS)-1:0] beat_len_t;

  // Log2 of bytes per beat or per element
  typedef logic [2:0] size_t;

  // Decoder FSM
  typedef enum logic [1:0] {
    DEC_IDLE,
    DEC_CHECK,
    DEC_BUSY
  } dec_state_e;

  // Sequencer FSM, shared by both sequencers
  typedef enum logic {
    SEQ_IDLE,
    SEQ_ISSUE
  } seq_state_e;

endpackage

`default_nettype wire

//--- hdl/addrgen_cfg.svh
////////////////////////////////////////////////////////////
// Address generator configuration
// Bus geometry, burst limits and descriptor queue sizing
////////////////////////////////////////////////////////////

`ifndef ADDRGEN_CFG_SVH
`define ADDRGEN_CFG_SVH

// Byte address width
`define ADDRGEN_ADDR_W 32
// Vector length counter width in elements
`define ADDRGEN_LEN_W 16

// Data bus is 64 bits wide
`define ADDRGEN_DATA_BYTES 8
`define ADDRGEN_DATA_SIZE 3

// Longest INCR burst and page size
`define ADDRGEN_MAX_BEATS 256
`define ADDRGEN_PAGE_BITS 12

// Descriptors held for the load/store units
`define ADDRGEN_QUEUE_DEPTH 2

`endif
